// File: verilog.f
rtl/daf_pkg.sv
rtl/frame_pipe_reg.sv
rtl/amp_clipper.sv
rtl/amp_compressor.sv
rtl/volume_scaler.sv
rtl/daf_ampcom.sv
test/tb_clock_gen.sv
test/tb_daf_ampcom.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and check the result line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_daf_ampcom -f verilog.f \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_daf_ampcom)"
echo "$sim_out"

echo "$sim_out" | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: test/tb_daf_ampcom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the clipper/compressor/volume chain
// drives frames through each effect alone, then all of them
// under back-pressure; a model queue checks every output frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_daf_ampcom;

  import daf_pkg::*;

  localparam logic [31:0] RAND_SEED = 32'ha585_6b0c;
  // frames per test, summed for the watchdog
  localparam int N_PASS  = 20;
  localparam int N_CLIP  = 4 * 12;
  localparam int N_COMP  = 4 * 10;
  localparam int N_VOL   = 3 * 10;
  localparam int N_MIX   = 4 * 50;
  localparam int N_TOTAL = N_PASS + N_CLIP + N_COMP + N_VOL + N_MIX;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 4 + 500;
  // longest wait for the pipeline to empty after a test
  localparam int DRAIN_CYCLES = 50;

  logic          tb_clk;
  logic          rst_n;
  pot_t          pot_vol;
  pot_t          pot_amp_clp;
  pot_t          pot_amp_com;
  effect_mode_t  swch_mode_en;
  stereo_frame_t in_frame;
  logic          in_valid;
  logic          in_ready;
  stereo_frame_t out_frame;
  logic          out_valid;
  logic          out_ready;

  // scoreboard state
  stereo_frame_t exp_q[$];
  int            acc_q[$];
  string         name_q[$];
  string         test_name;
  bit            check_latency;
  bit            bp_on;
  int            cycle_cnt;
  int            in_count;
  int            out_count;
  int            errors;

  tb_clock_gen clk_gen_i (
    .tb_clk (tb_clk)
  );

  daf_ampcom dut_i (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .pot_vol      (pot_vol),
    .pot_amp_clp  (pot_amp_clp),
    .pot_amp_com  (pot_amp_com),
    .swch_mode_en (swch_mode_en),
    .in_frame     (in_frame),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_frame    (out_frame),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  // reference rules, one channel at a time on plain ints
  function automatic int clip_ref(int x, pot_t pot);
    int th;
    th = (int'(pot) + 1) * CLIP_STEP;
    if (th > SAMPLE_MAX) th = SAMPLE_MAX;
    if (x > th) return th;
    if (x < -th) return -th;
    return x;
  endfunction

  function automatic int comp_ref(int x, pot_t pot);
    int mag;
    int sh;
    sh  = int'(pot[3:2]);
    mag = (x < 0) ? -x : x;
    if (mag > COMP_KNEE) mag = COMP_KNEE + ((mag - COMP_KNEE) >>> sh);
    return (x < 0) ? -mag : mag;
  endfunction

  function automatic int vol_ref(int x, pot_t pot);
    int y;
    // floor division by 8
    y = (x * int'(pot)) >>> VOL_SHIFT;
    if (y > SAMPLE_MAX) return SAMPLE_MAX;
    if (y < SAMPLE_MIN) return SAMPLE_MIN;
    return y;
  endfunction

  function automatic int chain_ref(int x, effect_mode_t m, pot_t pc, pot_t pm, pot_t pv);
    int y;
    y = x;
    if (m.amp_clip_en) y = clip_ref(y, pc);
    if (m.amp_comp_en) y = comp_ref(y, pm);
    if (m.vol_en) y = vol_ref(y, pv);
    return y;
  endfunction

  function automatic stereo_frame_t model_frame(stereo_frame_t f, effect_mode_t m,
                                                pot_t pc, pot_t pm, pot_t pv);
    stereo_frame_t r;
    r.left  = sample_t'(chain_ref(int'(f.left), m, pc, pm, pv));
    r.right = sample_t'(chain_ref(int'(f.right), m, pc, pm, pv));
    return r;
  endfunction

  function automatic stereo_frame_t make_frame(int l, int r);
    stereo_frame_t f;
    f.left  = sample_t'(l);
    f.right = sample_t'(r);
    return f;
  endfunction

  // full scale now and then, otherwise any 16-bit value
  function automatic sample_t rand_sample();
    case ($urandom % 8)
      0: return sample_t'(SAMPLE_MAX);
      1: return sample_t'(SAMPLE_MIN);
      default: return sample_t'($urandom);
    endcase
  endfunction

  function automatic stereo_frame_t rand_frame();
    stereo_frame_t f;
    f.left  = rand_sample();
    f.right = rand_sample();
    return f;
  endfunction

  always @(posedge tb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // random back-pressure from the sink
  always @(posedge tb_clk) begin
    if (bp_on) out_ready <= ($urandom % 4) != 0;
    else out_ready <= 1'b1;
  end

  // expected frame is fixed when the input side accepts it
  always @(posedge tb_clk) begin
    if (rst_n && in_valid && in_ready) begin
      exp_q.push_back(model_frame(in_frame, swch_mode_en, pot_amp_clp, pot_amp_com, pot_vol));
      acc_q.push_back(check_latency ? cycle_cnt : -1);
      name_q.push_back(test_name);
      in_count++;
    end
  end

  always @(posedge tb_clk) begin : compare_out
    stereo_frame_t exp_f;
    int            acc;
    string         nm;
    if (rst_n && out_valid && out_ready) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("Error: output frame %h arrived while no frame was expected", out_frame);
        errors++;
      end else begin
        exp_f = exp_q.pop_front();
        acc   = acc_q.pop_front();
        nm    = name_q.pop_front();
        if (out_frame !== exp_f) begin
          $display("Fail %s: expected %h, actual %h", nm, exp_f, out_frame);
          errors++;
        end
        if (acc >= 0 && cycle_cnt - acc != STAGE_COUNT) begin
          $display("Fail %s latency: expected %0d, actual %0d", nm, STAGE_COUNT,
                   cycle_cnt - acc);
          errors++;
        end
      end
    end
  end

  // present a frame and hold it until the DUT takes it
  task automatic send_frame(stereo_frame_t f);
    in_frame <= f;
    in_valid <= 1'b1;
    @(posedge tb_clk);
    while (!in_ready) @(posedge tb_clk);
  endtask

  // stop the source and give the pipeline a bounded time to empty
  task automatic drain();
    int waited;
    waited = 0;
    in_valid <= 1'b0;
    @(posedge tb_clk);
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge tb_clk);
      waited++;
    end
    repeat (2) @(posedge tb_clk);
  endtask

  // knobs only move while the pipeline is empty
  task automatic set_knobs(effect_mode_t m, pot_t pc, pot_t pm, pot_t pv);
    swch_mode_en <= m;
    pot_amp_clp  <= pc;
    pot_amp_com  <= pm;
    pot_vol      <= pv;
    @(posedge tb_clk);
  endtask

  initial begin
    pot_t clip_pots[4];
    pot_t vol_pots[3];
    clip_pots = '{4'd0, 4'd3, 4'd7, 4'd15};
    vol_pots  = '{4'd0, 4'd8, 4'd15};
    void'($urandom(RAND_SEED));
    rst_n        = 1'b0;
    pot_vol      = '0;
    pot_amp_clp  = '0;
    pot_amp_com  = '0;
    swch_mode_en = '0;
    in_frame     = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    bp_on        = 1'b0;
    check_latency = 1'b0;
    cycle_cnt    = 0;
    in_count     = 0;
    out_count    = 0;
    errors       = 0;
    test_name    = "reset";

    repeat (2) @(posedge tb_clk);
    rst_n <= 1'b1;
    @(posedge tb_clk);
    if (out_valid !== 1'b0) begin
      $display("Fail reset: out_valid expected 0, actual %b", out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("Fail reset: in_ready expected 1, actual %b", in_ready);
      errors++;
    end

    // all effects bypassed, back to back
    test_name = "bypass";
    check_latency = 1'b1;
    set_knobs(3'b000, 4'd5, 4'd9, 4'd3);
    send_frame(make_frame(SAMPLE_MAX, SAMPLE_MIN));
    send_frame(make_frame(0, -1));
    for (int i = 2; i < N_PASS; i++) send_frame(rand_frame());
    drain();
    check_latency = 1'b0;

    test_name = "clipper";
    foreach (clip_pots[p]) begin
      set_knobs(3'b100, clip_pots[p], 4'd0, 4'd8);
      send_frame(make_frame(SAMPLE_MAX, SAMPLE_MIN));
      send_frame(make_frame(SAMPLE_MIN, SAMPLE_MAX));
      for (int i = 2; i < 12; i++) send_frame(rand_frame());
      drain();
    end

    // low pot bits do not matter to the ratio
    test_name = "compressor";
    for (int sh = 0; sh < 4; sh++) begin
      set_knobs(3'b010, 4'd0, pot_t'({sh[1:0], 2'($urandom)}), 4'd8);
      send_frame(make_frame(COMP_KNEE, -COMP_KNEE));
      send_frame(make_frame(COMP_KNEE + 1, -COMP_KNEE - 1));
      send_frame(make_frame(SAMPLE_MAX, SAMPLE_MIN));
      send_frame(make_frame(20000, -20000));
      send_frame(make_frame(100, -5000));
      send_frame(make_frame(-9000, 8191));
      for (int i = 6; i < 10; i++) send_frame(rand_frame());
      drain();
    end

    test_name = "volume";
    foreach (vol_pots[p]) begin
      set_knobs(3'b001, 4'd0, 4'd0, vol_pots[p]);
      send_frame(make_frame(SAMPLE_MAX, SAMPLE_MIN));
      send_frame(make_frame(4096, -4096));
      send_frame(make_frame(1, -1));
      send_frame(make_frame(20000, -20001));
      for (int i = 4; i < 10; i++) send_frame(rand_frame());
      drain();
    end

    // everything on, gaps at the input and stalls at the output
    test_name = "full_chain";
    bp_on = 1'b1;
    for (int b = 0; b < 4; b++) begin
      set_knobs(3'b111, pot_t'($urandom), pot_t'($urandom), pot_t'($urandom));
      for (int i = 0; i < 50; i++) begin
        if ($urandom % 4 == 0) begin
          in_valid <= 1'b0;
          @(posedge tb_clk);
        end
        send_frame(rand_frame());
      end
      drain();
    end
    bp_on = 1'b0;
    repeat (4) @(posedge tb_clk);

    if (exp_q.size() != 0) begin
      $display("Error: %0d expected frames never came out of the DUT", exp_q.size());
      errors++;
    end
    if (in_count != out_count) begin
      $display("Error: %0d frames went in but %0d came out", in_count, out_count);
      errors++;
    end
    $display("errors: %0d, frames in: %0d, frames out: %0d", errors, in_count, out_count);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge tb_clk);
    $display("Error: watchdog expired after %0d cycles, the test did not finish",
             WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free-running testbench clock, 20 ns period
// instantiated once by the testbench top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clock_gen (
  output logic tb_clk
);

  // half of the 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    tb_clk = 1'b0;
    forever begin
      #(HALF_PERIOD) tb_clk = ~tb_clk;
    end
  end

endmodule

// File: rtl/daf_ampcom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the effects processor
// clipper -> compressor -> volume, one frame per cycle
// three cycles from in_frame to out_frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module daf_ampcom (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  daf_pkg::pot_t          pot_vol,
  input  daf_pkg::pot_t          pot_amp_clp,
  input  daf_pkg::pot_t          pot_amp_com,
  input  daf_pkg::effect_mode_t  swch_mode_en,
  input  daf_pkg::stereo_frame_t in_frame,
  input  logic                   in_valid,
  output logic                   in_ready,
  output daf_pkg::stereo_frame_t out_frame,
  output logic                   out_valid,
  input  logic                   out_ready
);

  import daf_pkg::*;

  // clipper to compressor
  stereo_frame_t clp_frame;
  logic          clp_valid;
  logic          clp_ready;

  // compressor to volume
  stereo_frame_t cmp_frame;
  logic          cmp_valid;
  logic          cmp_ready;

  amp_clipper u_clipper (
    .tb_clk      (tb_clk),
    .rst_n       (rst_n),
    .pot_amp_clp (pot_amp_clp),
    .clip_en     (swch_mode_en.amp_clip_en),
    .s_frame     (in_frame),
    .s_valid     (in_valid),
    .s_ready     (in_ready),
    .m_frame     (clp_frame),
    .m_valid     (clp_valid),
    .m_ready     (clp_ready)
  );

  amp_compressor u_compressor (
    .tb_clk      (tb_clk),
    .rst_n       (rst_n),
    .pot_amp_com (pot_amp_com),
    .comp_en     (swch_mode_en.amp_comp_en),
    .s_frame     (clp_frame),
    .s_valid     (clp_valid),
    .s_ready     (clp_ready),
    .m_frame     (cmp_frame),
    .m_valid     (cmp_valid),
    .m_ready     (cmp_ready)
  );

  // Last stage drives the output port directly
  volume_scaler u_volume (
    .tb_clk  (tb_clk),
    .rst_n   (rst_n),
    .pot_vol (pot_vol),
    .vol_en  (swch_mode_en.vol_en),
    .s_frame (cmp_frame),
    .s_valid (cmp_valid),
    .s_ready (cmp_ready),
    .m_frame (out_frame),
    .m_valid (out_valid),
    .m_ready (out_ready)
  );

endmodule

// File: rtl/volume_scaler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// volume stage, last effect in the chain
// gain is pot/8, result saturates to the 16-bit range
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module volume_scaler (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  daf_pkg::pot_t          pot_vol,
  input  logic                   vol_en,
  input  daf_pkg::stereo_frame_t s_frame,
  input  logic                   s_valid,
  output logic                   s_ready,
  output daf_pkg::stereo_frame_t m_frame,
  output logic                   m_valid,
  input  logic                   m_ready
);

  import daf_pkg::*;

  stereo_frame_t vol_frame;
  stereo_frame_t stage_frame;

  // 16 x 5 bit signed product fits in 21 bits
  function automatic sample_t vol_sample(sample_t x, pot_t g);
    logic signed [20:0] prod;
    logic signed [20:0] scaled;
    prod   = x * $signed({1'b0, g});
    // arithmetic shift, rounds toward minus infinity
    scaled = prod >>> VOL_SHIFT;
    if (scaled > SAMPLE_MAX) begin
      return sample_t'(SAMPLE_MAX);
    end else if (scaled < SAMPLE_MIN) begin
      return sample_t'(SAMPLE_MIN);
    end
    return sample_t'(scaled);
  endfunction

  assign vol_frame.left  = vol_sample(s_frame.left, pot_vol);
  assign vol_frame.right = vol_sample(s_frame.right, pot_vol);

  assign stage_frame = vol_en ? vol_frame : s_frame;

  frame_pipe_reg u_reg (
    .tb_clk  (tb_clk),
    .rst_n   (rst_n),
    .s_frame (stage_frame),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_frame (m_frame),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

endmodule

// File: rtl/amp_compressor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// level compressor, second effect in the chain
// level above the knee is cut by 2**(pot[3:2]), sign is kept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module amp_compressor (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  daf_pkg::pot_t          pot_amp_com,
  input  logic                   comp_en,
  input  daf_pkg::stereo_frame_t s_frame,
  input  logic                   s_valid,
  output logic                   s_ready,
  output daf_pkg::stereo_frame_t m_frame,
  output logic                   m_valid,
  input  logic                   m_ready
);

  import daf_pkg::*;

  logic [1:0]    ratio_shift;
  stereo_frame_t comp_frame;
  stereo_frame_t stage_frame;
  logic [16:0]   in_mag_l;
  logic [16:0]   in_mag_r;
  logic [16:0]   out_mag_l;
  logic [16:0]   out_mag_r;

  // 17 bits so that -32768 has a magnitude
  function automatic logic [16:0] abs_mag(sample_t x);
    logic [16:0] ext;
    ext = {x[15], x};
    return x[15] ? (17'd0 - ext) : ext;
  endfunction

  function automatic sample_t comp_sample(sample_t x, logic [1:0] sh);
    logic [16:0] mag;
    logic [16:0] new_mag;
    logic [16:0] neg_mag;
    mag = abs_mag(x);
    if (mag > 17'(COMP_KNEE)) begin
      new_mag = 17'(COMP_KNEE) + ((mag - 17'(COMP_KNEE)) >> sh);
    end else begin
      new_mag = mag;
    end
    // shift 0 on -32768 gives back 32768, which still fits as negative
    neg_mag = 17'd0 - new_mag;
    return x[15] ? sample_t'(neg_mag) : sample_t'(new_mag);
  endfunction

  // ratio 1:1, 2:1, 4:1 or 8:1
  assign ratio_shift = pot_amp_com[3:2];

  assign comp_frame.left  = comp_sample(s_frame.left, ratio_shift);
  assign comp_frame.right = comp_sample(s_frame.right, ratio_shift);

  assign stage_frame = comp_en ? comp_frame : s_frame;

  frame_pipe_reg u_reg (
    .tb_clk  (tb_clk),
    .rst_n   (rst_n),
    .s_frame (stage_frame),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_frame (m_frame),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  // magnitudes on both sides of the register, for the check below
  assign in_mag_l  = abs_mag(s_frame.left);
  assign in_mag_r  = abs_mag(s_frame.right);
  assign out_mag_l = abs_mag(m_frame.left);
  assign out_mag_r = abs_mag(m_frame.right);

  // compression never adds level, bypass or not
  a_no_gain: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (s_valid && s_ready) |=> (out_mag_l <= $past(in_mag_l))
                          && (out_mag_r <= $past(in_mag_r))
  ) else $error("amp_compressor: output louder than input");

endmodule

// File: rtl/amp_clipper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hard clipper, first effect in the chain
// limits both channels to +/- a pot-selected threshold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module amp_clipper (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  daf_pkg::pot_t          pot_amp_clp,
  input  logic                   clip_en,
  input  daf_pkg::stereo_frame_t s_frame,
  input  logic                   s_valid,
  output logic                   s_ready,
  output daf_pkg::stereo_frame_t m_frame,
  output logic                   m_valid,
  input  logic                   m_ready
);

  import daf_pkg::*;

  int            thresh_raw;
  sample_t       thresh;
  stereo_frame_t clip_frame;
  stereo_frame_t stage_frame;

  // clamp one sample into [-th, th]
  function automatic sample_t clip_sample(sample_t x, sample_t th);
    if (x > th) begin
      return th;
    end else if (x < -th) begin
      return -th;
    end
    return x;
  endfunction

  // threshold steps, top step capped to full scale
  assign thresh_raw = (int'(pot_amp_clp) + 1) * CLIP_STEP;
  assign thresh     = (thresh_raw > SAMPLE_MAX) ? sample_t'(SAMPLE_MAX)
                                                : sample_t'(thresh_raw);

  assign clip_frame.left  = clip_sample(s_frame.left, thresh);
  assign clip_frame.right = clip_sample(s_frame.right, thresh);

  // bypass keeps the same register, so latency does not change
  assign stage_frame = clip_en ? clip_frame : s_frame;

  frame_pipe_reg u_reg (
    .tb_clk  (tb_clk),
    .rst_n   (rst_n),
    .s_frame (stage_frame),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_frame (m_frame),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

endmodule

// File: rtl/frame_pipe_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-deep valid/ready register for a stereo frame
// every effect stage ends in one of these
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module frame_pipe_reg (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  daf_pkg::stereo_frame_t s_frame,
  input  logic                   s_valid,
  output logic                   s_ready,
  output daf_pkg::stereo_frame_t m_frame,
  output logic                   m_valid,
  input  logic                   m_ready
);

  // free slot, or the held frame leaves this cycle
  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge tb_clk) begin
    if (s_valid && s_ready) begin
      m_frame <= s_frame;
    end
  end

  // a frame stalled at the input must not change under this stage
  a_frame_hold: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (s_valid && !s_ready) |=> $stable(s_frame)
  ) else $error("frame_pipe_reg: s_frame changed while stalled");

  // upstream valid only drops after this stage took the frame
  a_valid_hold: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (s_valid && !s_ready) |=> s_valid
  ) else $error("frame_pipe_reg: s_valid dropped without a transfer");

endmodule

// File: rtl/daf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the audio effects chain
// stages, top and testbench pull frame and knob types from here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package daf_pkg;

  // one signed pcm sample
  typedef logic signed [15:0] sample_t;

  // stereo frame, left channel sits in the upper half
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_frame_t;

  // front panel knob, 0 to 15
  typedef logic [3:0] pot_t;

  // effect enables, in chain order
  typedef struct packed {
    logic amp_clip_en;
    logic amp_comp_en;
    logic vol_en;
  } effect_mode_t;

  // 16-bit saturation limits
  localparam int SAMPLE_MAX = 32767;
  localparam int SAMPLE_MIN = -32768;

  // clip threshold is (pot + 1) * CLIP_STEP
  // pot 15 lands one above SAMPLE_MAX and gets capped
  localparam int CLIP_STEP = 2048;

  // compression only touches magnitudes above the knee
  localparam int COMP_KNEE = 8192;

  // volume gain is pot / 2**VOL_SHIFT, so pot 8 is unity
  localparam int VOL_SHIFT = 3;

  // one register per effect
  localparam int STAGE_COUNT = 3;

endpackage
